// ==== design/tinker_pkg.sv ====
// Tinker core shared definitions
// Widths, opcode encoding, instruction field positions and reset PC
`default_nettype none

package tinker_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int word_w   = 64;
    localparam int instr_w  = 32;
    localparam int addr_w   = 32;
    localparam int reg_w    = 5;
    localparam int lit_w    = 12;
    localparam int op_w     = 5;
    localparam int num_regs = 32;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [instr_w-1:0] instr_t;
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [reg_w-1:0]   reg_idx_t;
    typedef logic [lit_w-1:0]   literal_t;

    // Opcodes not listed here behave as no-ops
    typedef enum logic [op_w-1:0] {
        op_and     = 5'b00000,
        op_or      = 5'b00001,
        op_xor     = 5'b00010,
        op_not     = 5'b00011,
        op_shftr   = 5'b00100,
        op_shftri  = 5'b00101,
        op_shftl   = 5'b00110,
        op_shftli  = 5'b00111,
        op_brr     = 5'b01000,  // pc = rd
        op_brr_rel = 5'b01001,  // pc = pc + rd
        op_br_rel  = 5'b01010,  // pc = pc + L
        op_brnz    = 5'b01011,
        op_brgt    = 5'b01110,
        op_halt    = 5'b01111,
        op_load    = 5'b10000,
        op_mov     = 5'b10001,
        op_mov_lit = 5'b10010,
        op_store   = 5'b10011,
        op_add     = 5'b11000,
        op_addi    = 5'b11001,
        op_sub     = 5'b11010,
        op_subi    = 5'b11011,
        op_mul     = 5'b11100,
        op_nop     = 5'b11110
    } opcode_t;

    // ------------------------------------------------------------------
    // Instruction fields, msb of each
    // ------------------------------------------------------------------
    localparam int opcode_msb  = 31;
    localparam int rd_msb      = 26;
    localparam int rs_msb      = 21;
    localparam int rt_msb      = 16;
    localparam int literal_msb = 11;

    localparam addr_t instr_bytes   = 32'd4;
    localparam addr_t reset_pc      = 32'h0000_2000;
    localparam int    mov_lit_shift = 52;  // mov literal lands in 63:52

endpackage

`default_nettype wire

// ==== design/fetch_stage.sv ====
// Tinker fetch stage
// Holds the PC, takes branch redirects and loads the fetch/decode register
`timescale 1ns/100ps
`default_nettype none

module fetch_stage import tinker_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire         taken,
    input  wire addr_t  target,
    output addr_t       imem_addr,
    input  wire instr_t imem_data,
    output instr_t      id_instr,
    output addr_t       id_pc
);

    addr_t pc;

    assign imem_addr = pc;  // Memory answers in the same cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc       <= reset_pc;
            id_instr <= {op_nop, {(instr_w-op_w){1'b0}}};
        end else begin
            pc       <= taken ? target : pc + instr_bytes;
            id_instr <= imem_data;
        end
    end

    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

    // Redirect targets come from register values, so check alignment here
    pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
// Tinker decode stage
// Splits the instruction fields, picks the literal or rt operand,
// flags halt and loads the decode/execute register
`timescale 1ns/100ps
`default_nettype none

module decode_stage import tinker_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire instr_t id_instr,
    input  wire addr_t  id_pc,
    output reg_idx_t    rs_idx,
    output reg_idx_t    rt_idx,
    output reg_idx_t    rd_idx,
    input  wire word_t  rs_val,
    input  wire word_t  rt_val,
    input  wire word_t  rd_val,
    output logic        hlt,
    output opcode_t     ex_op,
    output reg_idx_t    ex_dest,
    output word_t       ex_a,
    output word_t       ex_b,
    output word_t       ex_rd_val,
    output addr_t       ex_pc
);

    opcode_t  op;
    literal_t lit;
    word_t    lit_ext;
    logic     use_lit;

    // ------------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------------
    assign op      = opcode_t'(id_instr[opcode_msb -: op_w]);
    assign rd_idx  = id_instr[rd_msb -: reg_w];
    assign rs_idx  = id_instr[rs_msb -: reg_w];
    assign rt_idx  = id_instr[rt_msb -: reg_w];
    assign lit     = id_instr[literal_msb -: lit_w];
    assign lit_ext = {{(word_w-lit_w){lit[lit_w-1]}}, lit};  // Sign extend

    // Literal forms take L in place of rt
    always_comb begin
        case (op)
            op_addi, op_subi, op_shftri, op_shftli,
            op_mov_lit, op_br_rel, op_store, op_load: use_lit = 1'b1;
            default:                                  use_lit = 1'b0;
        endcase
    end

    // Only halt with a zero literal stops the core
    assign hlt = (op == op_halt) && (lit == '0);

    // ------------------------------------------------------------------
    // Decode/execute register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_op <= op_nop;
        end else begin
            ex_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        ex_dest   <= rd_idx;
        ex_a      <= rs_val;
        ex_b      <= use_lit ? lit_ext : rt_val;
        ex_rd_val <= rd_val;  // Branch target, store base, mov literal base
        ex_pc     <= id_pc;
    end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
// Tinker register file
// 32 registers of 64 bits, three combinational reads, one clocked write
`timescale 1ns/100ps
`default_nettype none

module register_file import tinker_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire reg_idx_t rs_idx,
    input  wire reg_idx_t rt_idx,
    input  wire reg_idx_t rd_idx,
    output word_t         rs_val,
    output word_t         rt_val,
    output word_t         rd_val,
    input  wire           wr_en,
    input  wire reg_idx_t wr_idx,
    input  wire word_t    wr_data
);

    word_t regs [num_regs];

    assign rs_val = regs[rs_idx];
    assign rt_val = regs[rt_idx];
    assign rd_val = regs[rd_idx];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;  // r31 included
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Catches loads from unwritten memory reaching the registers
    wr_data_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_data));

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
// Tinker execute stage
// ALU, branch decision and target, data address generation,
// and the execute/memory register
`timescale 1ns/100ps
`default_nettype none

module execute_stage import tinker_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire opcode_t   ex_op,
    input  wire reg_idx_t  ex_dest,
    input  wire word_t     ex_a,
    input  wire word_t     ex_b,
    input  wire word_t     ex_rd_val,
    input  wire addr_t     ex_pc,
    output logic           taken,
    output addr_t          target,
    output addr_t          dmem_addr,
    output word_t          dmem_wdata,
    output logic           dmem_write,
    output word_t          mem_result,
    output reg_idx_t       mem_dest,
    output logic           mem_wr_en,
    output logic           mem_is_load
);

    word_t alu_res;
    addr_t addr_c;
    addr_t target_c;
    logic  wr_en_c;
    logic  load_c;
    logic  store_c;
    logic  taken_c;

    // ------------------------------------------------------------------
    // ALU and branch unit
    // ------------------------------------------------------------------
    always_comb begin
        alu_res  = '0;
        addr_c   = '0;
        target_c = '0;
        wr_en_c  = 1'b1;
        load_c   = 1'b0;
        store_c  = 1'b0;
        taken_c  = 1'b0;
        case (ex_op)
            op_add, op_addi:     alu_res = ex_a + ex_b;
            op_sub, op_subi:     alu_res = ex_a - ex_b;
            op_mul:              alu_res = ex_a * ex_b;  // Low 64 bits
            op_and:              alu_res = ex_a & ex_b;
            op_or:               alu_res = ex_a | ex_b;
            op_xor:              alu_res = ex_a ^ ex_b;
            op_not:              alu_res = ~ex_a;
            op_shftr, op_shftri: alu_res = ex_a >> ex_b;
            op_shftl, op_shftli: alu_res = ex_a << ex_b;
            op_mov:              alu_res = ex_a;
            op_mov_lit: begin
                // Top 12 bits replaced, rest of rd kept
                alu_res = {ex_b[lit_w-1:0], ex_rd_val[mov_lit_shift-1:0]};
            end
            op_load: begin
                load_c = 1'b1;
                addr_c = addr_t'(ex_a + ex_b);  // rs + L
            end
            op_store: begin
                wr_en_c = 1'b0;
                store_c = 1'b1;
                addr_c  = addr_t'(ex_rd_val + ex_b);  // rd + L
            end
            op_brr: begin
                wr_en_c  = 1'b0;
                taken_c  = 1'b1;
                target_c = addr_t'(ex_rd_val);
            end
            op_brr_rel: begin
                wr_en_c  = 1'b0;
                taken_c  = 1'b1;
                target_c = ex_pc + addr_t'(ex_rd_val);
            end
            op_br_rel: begin
                wr_en_c  = 1'b0;
                taken_c  = 1'b1;
                target_c = ex_pc + addr_t'(ex_b);
            end
            op_brnz: begin
                wr_en_c  = 1'b0;
                taken_c  = (ex_a != '0);
                target_c = addr_t'(ex_rd_val);
            end
            op_brgt: begin
                wr_en_c  = 1'b0;
                taken_c  = ($signed(ex_a) > $signed(ex_b));
                target_c = addr_t'(ex_rd_val);
            end
            default: wr_en_c = 1'b0;  // halt and no-op
        endcase
    end

    // ------------------------------------------------------------------
    // Execute/memory register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            taken       <= 1'b0;
            dmem_write  <= 1'b0;
            mem_wr_en   <= 1'b0;
            mem_is_load <= 1'b0;
        end else begin
            taken       <= taken_c;
            dmem_write  <= store_c;
            mem_wr_en   <= wr_en_c;
            mem_is_load <= load_c;
        end
    end

    always_ff @(posedge clk) begin
        target     <= target_c;
        dmem_addr  <= addr_c;
        dmem_wdata <= ex_a;  // Store data is rs
        mem_result <= alu_res;
        mem_dest   <= ex_dest;
    end

    // Store strobe goes out with a known address and data
    store_known: assert property (@(posedge clk) disable iff (reset)
        dmem_write |-> !$isunknown({dmem_addr, dmem_wdata}));

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
// Tinker memory stage
// Captures load data and selects the write-back value
`timescale 1ns/100ps
`default_nettype none

module memory_stage import tinker_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire word_t    mem_result,
    input  wire word_t    dmem_rdata,
    input  wire reg_idx_t mem_dest,
    input  wire           mem_wr_en,
    input  wire           mem_is_load,
    output logic          wr_en,
    output reg_idx_t      wr_idx,
    output word_t         wr_data
);

    word_t result_q;
    word_t load_q;
    logic  is_load_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_en     <= 1'b0;
            is_load_q <= 1'b0;
        end else begin
            wr_en     <= mem_wr_en;
            is_load_q <= mem_is_load;
        end
    end

    always_ff @(posedge clk) begin
        wr_idx   <= mem_dest;
        result_q <= mem_result;
        load_q   <= dmem_rdata;  // Valid only for loads
    end

    assign wr_data = is_load_q ? load_q : result_q;

endmodule

`default_nettype wire

// ==== design/tinker_core.sv ====
// Tinker core top level
// Five-stage in-order pipeline without forwarding or stalls,
// instruction and data memory kept outside the core
`timescale 1ns/100ps
`default_nettype none

module tinker_core import tinker_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    output addr_t       imem_addr,
    input  wire instr_t imem_data,
    output addr_t       dmem_addr,
    output word_t       dmem_wdata,
    output logic        dmem_write,
    input  wire word_t  dmem_rdata,
    output logic        hlt
);

    // Fetch to decode
    instr_t   id_instr;
    addr_t    id_pc;

    // Decode to register file and execute
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    reg_idx_t rd_idx;
    word_t    rs_val;
    word_t    rt_val;
    word_t    rd_val;
    opcode_t  ex_op;
    reg_idx_t ex_dest;
    word_t    ex_a;
    word_t    ex_b;
    word_t    ex_rd_val;
    addr_t    ex_pc;

    // Execute to fetch and memory
    logic     taken;
    addr_t    target;
    word_t    mem_result;
    reg_idx_t mem_dest;
    logic     mem_wr_en;
    logic     mem_is_load;

    // Write-back
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;

    // ------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------
    fetch_stage fetch0 (
        .clk       (clk),
        .reset     (reset),
        .taken     (taken),
        .target    (target),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .id_instr  (id_instr),
        .id_pc     (id_pc)
    );

    decode_stage decode0 (
        .clk       (clk),
        .reset     (reset),
        .id_instr  (id_instr),
        .id_pc     (id_pc),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rd_idx    (rd_idx),
        .rs_val    (rs_val),
        .rt_val    (rt_val),
        .rd_val    (rd_val),
        .hlt       (hlt),
        .ex_op     (ex_op),
        .ex_dest   (ex_dest),
        .ex_a      (ex_a),
        .ex_b      (ex_b),
        .ex_rd_val (ex_rd_val),
        .ex_pc     (ex_pc)
    );

    register_file regs0 (
        .clk     (clk),
        .reset   (reset),
        .rs_idx  (rs_idx),
        .rt_idx  (rt_idx),
        .rd_idx  (rd_idx),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .rd_val  (rd_val),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data)
    );

    execute_stage execute0 (
        .clk         (clk),
        .reset       (reset),
        .ex_op       (ex_op),
        .ex_dest     (ex_dest),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_rd_val   (ex_rd_val),
        .ex_pc       (ex_pc),
        .taken       (taken),
        .target      (target),
        .dmem_addr   (dmem_addr),
        .dmem_wdata  (dmem_wdata),
        .dmem_write  (dmem_write),
        .mem_result  (mem_result),
        .mem_dest    (mem_dest),
        .mem_wr_en   (mem_wr_en),
        .mem_is_load (mem_is_load)
    );

    memory_stage memory0 (
        .clk         (clk),
        .reset       (reset),
        .mem_result  (mem_result),
        .dmem_rdata  (dmem_rdata),
        .mem_dest    (mem_dest),
        .mem_wr_en   (mem_wr_en),
        .mem_is_load (mem_is_load),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data)
    );

endmodule

`default_nettype wire

// ==== include/tb_isa_model.svh ====
// Tinker ISA reference model for the testbench
// Encodes instructions, draws literals and executes one instruction
// against a sequential register and memory state
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic instr_t isa_encode(opcode_t op, reg_idx_t rd, reg_idx_t rs,
                                      reg_idx_t rt, literal_t lit);
    return {op, rd, rs, rt, lit};
endfunction

// 32-bit xorshift, one step
function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Branch outcome is returned, delay slots are handled by the caller
function automatic void isa_step(
    input  instr_t ins,
    input  addr_t  pc,
    ref    word_t  regs [num_regs],
    ref    word_t  mem [addr_t],
    output bit     taken,
    output addr_t  target,
    output bit     stored,
    output addr_t  st_addr,
    output word_t  st_data
);
    opcode_t  op;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
    word_t    d;
    word_t    lit;
    addr_t    ld_addr;

    op      = opcode_t'(ins[opcode_msb -: op_w]);
    rd      = ins[rd_msb -: reg_w];
    a       = regs[ins[rs_msb -: reg_w]];
    b       = regs[ins[rt_msb -: reg_w]];
    d       = regs[rd];
    lit     = {{(word_w-lit_w){ins[literal_msb]}}, ins[literal_msb -: lit_w]};
    ld_addr = addr_t'(a + lit);
    taken   = 1'b0;
    target  = '0;
    stored  = 1'b0;
    st_addr = '0;
    st_data = '0;
    case (op)
        op_add:     regs[rd] = a + b;
        op_addi:    regs[rd] = a + lit;
        op_sub:     regs[rd] = a - b;
        op_subi:    regs[rd] = a - lit;
        op_mul:     regs[rd] = a * b;
        op_and:     regs[rd] = a & b;
        op_or:      regs[rd] = a | b;
        op_xor:     regs[rd] = a ^ b;
        op_not:     regs[rd] = ~a;
        op_shftr:   regs[rd] = a >> b;
        op_shftri:  regs[rd] = a >> lit;
        op_shftl:   regs[rd] = a << b;
        op_shftli:  regs[rd] = a << lit;
        op_mov:     regs[rd] = a;
        op_mov_lit: regs[rd] = {lit[lit_w-1:0], d[mov_lit_shift-1:0]};
        op_load:    regs[rd] = mem.exists(ld_addr) ? mem[ld_addr] : '0;
        op_store: begin
            stored        = 1'b1;
            st_addr       = addr_t'(d + lit);
            st_data       = a;
            mem[st_addr]  = a;
        end
        op_brr: begin
            taken  = 1'b1;
            target = addr_t'(d);
        end
        op_brr_rel: begin
            taken  = 1'b1;
            target = pc + addr_t'(d);
        end
        op_br_rel: begin
            taken  = 1'b1;
            target = pc + addr_t'(lit);
        end
        op_brnz: begin
            taken  = (a != '0);
            target = addr_t'(d);
        end
        op_brgt: begin
            taken  = ($signed(a) > $signed(b));
            target = addr_t'(d);
        end
        default: ;  // halt and no-op change nothing
    endcase
endfunction

`endif

// ==== testbench/tinker_tb.sv ====
// Tinker core testbench
// Builds a program, runs it on the core and on a sequential ISA model,
// and checks every data store against the model's store sequence
`timescale 1ns/100ps
`default_nettype none

module tinker_tb import tinker_pkg::*; ();

    `include "tb_isa_model.svh"

    localparam addr_t  data_base    = 32'h0000_1000;
    localparam int     gap_nops     = 4;
    localparam int     branch_slots = 3;
    localparam instr_t nop_instr    = {op_nop, 27'd0};

    logic   clk;
    logic   reset;
    addr_t  imem_addr;
    instr_t imem_data;
    addr_t  dmem_addr;
    word_t  dmem_wdata;
    logic   dmem_write;
    word_t  dmem_rdata;
    logic   hlt;

    instr_t      prog [$];
    word_t       dmem [addr_t];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    string       store_name [addr_t];
    logic [31:0] rand_state;
    int          next_slot;
    int          errors;
    int          stores_seen;
    int          stores_expected;
    int          cycles;
    int          cycle_limit;
    bit          halted;

    tinker_core dut0 (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .hlt        (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Program construction
    // ------------------------------------------------------------------
    function automatic literal_t rand_literal();
        rand_state = xorshift32(rand_state);
        return rand_state[lit_w-1:0];
    endfunction

    // Every real instruction is padded with no-ops
    function automatic int emit_instr(opcode_t op, int rd, int rs, int rt, int lit);
        int idx;
        idx = prog.size();
        prog.push_back(isa_encode(op, reg_idx_t'(rd), reg_idx_t'(rs), reg_idx_t'(rt),
                                  literal_t'(lit)));
        for (int i = 0; i < gap_nops; i++) begin
            prog.push_back(nop_instr);
        end
        return idx;
    endfunction

    function automatic void store_to(int src, string name);
        store_name[data_base + addr_t'(next_slot * 8)] = name;
        void'(emit_instr(op_store, 30, src, 0, next_slot * 8));  // r30 + L
        next_slot++;
    endfunction

    function automatic void patch_literal(int idx, int value);
        instr_t ins;
        ins = prog[idx];
        ins[literal_msb -: lit_w] = literal_t'(value);
        prog[idx] = ins;
    endfunction

    // Target held in r21 as r20 + offset, r20 holds reset_pc
    function automatic void abs_branch(opcode_t op, int rs, int rt, int src, string name);
        int fix;
        fix = emit_instr(op_addi, 21, 20, 0, 0);
        void'(emit_instr(op, 21, rs, rt, 0));
        store_to(src, {name, " next"});
        patch_literal(fix, prog.size() * 4);
        store_to(src, {name, " target"});
    endfunction

    function automatic void build_program();
        opcode_t alu_ops [14];
        opcode_t op;
        int      dst;
        int      lit;
        int      rt;
        int      add_slot;
        int      fix;
        int      br;
        alu_ops = '{op_add, op_sub, op_mul, op_and, op_or, op_xor, op_not, op_shftr,
                    op_shftl, op_mov, op_addi, op_subi, op_shftri, op_shftli};
        next_slot = 0;
        void'(emit_instr(op_addi, 30, 0, 0, 'h100));
        void'(emit_instr(op_shftli, 30, 30, 0, 4));  // Data base 0x1000
        void'(emit_instr(op_addi, 20, 0, 0, 'h400));
        void'(emit_instr(op_shftli, 20, 20, 0, 3));  // 0x2000
        void'(emit_instr(op_addi, 1, 0, 0, int'(rand_literal() | 12'h001)));  // Nonzero
        void'(emit_instr(op_addi, 2, 0, 0, int'(rand_literal())));
        void'(emit_instr(op_mov_lit, 2, 0, 0, int'(rand_literal())));
        store_to(2, "mov_lit r2");
        void'(emit_instr(op_addi, 29, 0, 0, int'(rand_literal()) % 64));  // Shift amount

        add_slot = next_slot;
        dst = 3;
        foreach (alu_ops[i]) begin
            op  = alu_ops[i];
            lit = int'(rand_literal());
            if (op inside {op_shftri, op_shftli}) begin
                lit = lit % 64;
            end
            rt = (op inside {op_shftr, op_shftl}) ? 29 : 1;
            void'(emit_instr(op, dst, 2, rt, lit));
            store_to(dst, op.name());
            dst++;
        end

        void'(emit_instr(op_mov, 17, 3, 0, 0));
        void'(emit_instr(op_mov_lit, 17, 0, 0, int'(rand_literal())));
        store_to(17, "mov_lit keeps low bits");
        void'(emit_instr(op_halt, 0, 0, 0, 1));  // Nonzero literal, no halt
        void'(emit_instr(op_load, 18, 30, 0, add_slot * 8));
        store_to(18, "load of add result");

        // ------------------------------------------------------------------
        // Branches
        // ------------------------------------------------------------------
        void'(emit_instr(op_addi, 24, 0, 0, 5));
        void'(emit_instr(op_addi, 25, 0, 0, -3));
        abs_branch(op_brr, 0, 0, 1, "brr");

        fix = emit_instr(op_addi, 22, 0, 0, 0);
        br  = emit_instr(op_brr_rel, 22, 0, 0, 0);
        store_to(2, "brr_rel next");
        patch_literal(fix, (prog.size() - br) * 4);
        store_to(2, "brr_rel target");

        br = emit_instr(op_br_rel, 0, 0, 0, 0);
        store_to(3, "br_rel next");
        patch_literal(br, (prog.size() - br) * 4);
        store_to(3, "br_rel target");

        abs_branch(op_brnz, 1, 0, 4, "brnz taken");
        abs_branch(op_brnz, 0, 0, 5, "brnz not taken");
        abs_branch(op_brgt, 24, 25, 6, "brgt taken");      // 5 > -3
        abs_branch(op_brgt, 25, 24, 7, "brgt not taken");
        void'(emit_instr(op_halt, 0, 0, 0, 0));
    endfunction

    function automatic instr_t fetch_word(addr_t pc);
        addr_t idx;
        idx = (pc - reset_pc) >> 2;
        if (pc < reset_pc || idx >= addr_t'(prog.size())) begin
            return nop_instr;
        end
        return prog[idx];
    endfunction

    // Sequential run with delay slots, fills the expected store queue
    function automatic void run_model();
        word_t  regs [num_regs];
        word_t  mem [addr_t];
        instr_t ins;
        addr_t  pc;
        addr_t  target;
        addr_t  jump_to;
        addr_t  st_addr;
        word_t  st_data;
        bit     taken;
        bit     stored;
        int     slots_left;
        int     steps;
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        pc         = reset_pc;
        jump_to    = '0;
        slots_left = 0;
        steps      = 0;
        while (steps < 2 * prog.size()) begin
            ins = fetch_word(pc);
            if (ins[opcode_msb -: op_w] == op_halt && ins[literal_msb -: lit_w] == '0) begin
                break;
            end
            isa_step(ins, pc, regs, mem, taken, target, stored, st_addr, st_data);
            if (stored) begin
                exp_addr.push_back(st_addr);
                exp_data.push_back(st_data);
            end
            if (slots_left > 0) begin
                slots_left--;
                pc = (slots_left == 0) ? jump_to : pc + instr_bytes;
            end else begin
                if (taken) begin
                    slots_left = branch_slots;
                    jump_to    = target;
                end
                pc = pc + instr_bytes;
            end
            steps++;
        end
        stores_expected = exp_addr.size();
    endfunction

    // ------------------------------------------------------------------
    // Memory model and store checking
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        #2;
        if (dmem_write === 1'b1) begin
            dmem[dmem_addr] = dmem_wdata;
        end
        imem_data = fetch_word(imem_addr);
        if (!$isunknown(dmem_addr) && dmem.exists(dmem_addr)) begin
            dmem_rdata = dmem[dmem_addr];
        end else begin
            dmem_rdata = '0;  // Unwritten memory reads as zero
        end
    end

    always @(negedge clk) begin : check_stores
        addr_t e_addr;
        word_t e_data;
        string name;
        if (dmem_write === 1'b1) begin
            stores_seen++;
            assert (exp_addr.size() > 0) else begin
                $display("Extra store to %h with data %h", dmem_addr, dmem_wdata);
                errors++;
            end
            if (exp_addr.size() > 0) begin
                e_addr = exp_addr.pop_front();
                e_data = exp_data.pop_front();
                name   = "unnamed";
                if (store_name.exists(e_addr)) begin
                    name = store_name[e_addr];
                end
                assert (dmem_addr == e_addr) else begin
                    $display("** Error %s address: expected %h, actual %h",
                             name, e_addr, dmem_addr);
                    errors++;
                end
                assert (dmem_wdata == e_data) else begin
                    $display("** Error %s data: expected %h, actual %h",
                             name, e_data, dmem_wdata);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    initial begin : main
        errors      = 0;
        stores_seen = 0;
        halted      = 1'b0;
        reset       = 1'b1;
        dmem_rdata  = '0;
        rand_state  = 32'hdc6e5924;
        build_program();
        run_model();
        cycle_limit = 5 * prog.size() + 50;
        imem_data   = fetch_word(reset_pc);
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        while (hlt !== 1'b1 && cycles < cycle_limit) begin
            @(negedge clk);
        end
        halted = (hlt === 1'b1);
        @(posedge clk);
        #2;
        if (!halted) begin
            $display("Timeout: hlt did not rise within %0d cycles", cycle_limit);
            errors++;
        end
        assert (exp_addr.size() == 0) else begin
            $display("%0d expected stores missing when the run ended", exp_addr.size());
            errors++;
        end
        $display("Stores seen %0d, expected %0d, errors %0d",
                 stores_seen, stores_expected, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/tinker_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/tinker_core.sv
testbench/tinker_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tinker_tb
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
